/* Makefile */
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module if_id_tb -f if_id_stage.f

sim:
	verilator --binary --timing --assert --top-module if_id_tb \
		-f if_id_stage.f -Mdir obj_dir -o if_id_sim
	./obj_dir/if_id_sim | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hw/fetch_sequencer.sv */
`timescale 1ns/1ns

module fetch_sequencer
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic ex_stall,
	input logic wb_stall,
	input logic [if_id_pkg::addr_width-1:0] computed_pc,
	input logic [if_id_pkg::group_width-1:0] group,
	input logic [if_id_pkg::oper_width-1:0] oper,
	input logic [if_id_pkg::reg_index_width-1:0] ra,
	input logic [if_id_pkg::reg_index_width-1:0] rb,
	input logic [if_id_pkg::reg_index_width-1:0] rc,
	input logic [if_id_pkg::addr_width-1:0] imm,
	input logic legal,
	output logic fetch_req,
	output logic [if_id_pkg::addr_width-1:0] fetch_addr,
	output logic ex_valid,
	output logic [if_id_pkg::group_width-1:0] ex_group,
	output logic [if_id_pkg::oper_width-1:0] ex_oper,
	output logic [if_id_pkg::reg_index_width-1:0] ex_ra,
	output logic [if_id_pkg::reg_index_width-1:0] ex_rb,
	output logic [if_id_pkg::reg_index_width-1:0] ex_rc,
	output logic [if_id_pkg::addr_width-1:0] ex_imm,
	output logic [if_id_pkg::addr_width-1:0] ex_pc,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_ra,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_rb,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_rc
);

	import if_id_pkg::*;

	fetch_state_t state;
	logic [addr_width-1:0] pc;
	logic [addr_width-1:0] next_pc;
	logic is_ctrl;
	logic take;
	logic hold;

	assign next_pc = pc + addr_width'(instr_bytes);
	assign is_ctrl = legal && (group == group_ctrl);

	// word accepted this cycle, or parked behind an execute stall
	assign take = (state == st_regular) && instr_valid && !ex_stall;
	assign hold = (state == st_regular) && instr_valid && ex_stall;

	always_comb
	begin
		fetch_req = 1'b0;
		fetch_addr = pc;
		if (rst_n)
		begin
			case (state)
				st_init:
					fetch_req = 1'b1;
				st_regular:
				begin
					// no point fetching past a branch
					fetch_req = !(instr_valid && is_ctrl);
					fetch_addr = next_pc;
				end
				st_change_pc:
				begin
					fetch_req = 1'b1;
					fetch_addr = computed_pc;
				end
				st_wait_mem_0, st_wait_mem_1:
					fetch_req = 1'b1;
				default:
					fetch_req = 1'b0;
			endcase
		end
	end

	// only the regular state exposes live indices
	assign ctrl_ra = (state == st_regular) ? ra : '0;
	assign ctrl_rb = (state == st_regular) ? rb : '0;
	assign ctrl_rc = (state == st_regular) ? rc : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_init;
			pc <= '0;
			ex_valid <= 1'b0;
		end
		else
		begin
			if (!hold)
				ex_valid <= take && legal;
			case (state)
				st_init:
					if (instr_valid)
						state <= st_regular;
				st_regular:
					if (take)
					begin
						pc <= next_pc;
						if (legal && (group == group_ctrl))
							state <= st_change_pc;
						else if (legal && (group == group_load || group == group_store))
							state <= st_wait_mem_0;
					end
				st_change_pc:
				begin
					pc <= computed_pc;
					state <= st_regular;
				end
				st_wait_mem_0:
					state <= st_wait_mem_1;
				st_wait_mem_1:
					if (!wb_stall)
						state <= st_regular;
				default:
					state <= st_init;
			endcase
		end
	end

	// payload, zero on a bubble
	always_ff @(posedge clk)
	begin
		if (take && legal)
		begin
			ex_group <= group;
			ex_oper <= oper;
			ex_ra <= ra;
			ex_rb <= rb;
			ex_rc <= rc;
			ex_imm <= imm;
			// branches hand execute the return address
			ex_pc <= (group == group_ctrl) ? next_pc : pc;
		end
		else if (!hold)
		begin
			ex_group <= '0;
			ex_oper <= '0;
			ex_ra <= '0;
			ex_rb <= '0;
			ex_rc <= '0;
			ex_imm <= '0;
			ex_pc <= '0;
		end
	end

	a_bubble_after_irregular: assert property (@(posedge clk) disable iff (!rst_n)
		(state != st_regular) |=> !ex_valid);

	a_no_fetch_in_reset: assert property (@(posedge clk)
		!rst_n |-> !fetch_req);

	// execute sees the same instruction for the whole stall
	a_stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
		hold |=> $stable(ex_pc));

endmodule

/* hw/if_id_pkg.sv */
package if_id_pkg;

	// instruction set widths
	localparam int instr_width = 32;
	localparam int addr_width = 64;
	localparam int instr_bytes = instr_width / 8;
	localparam int reg_index_width = 4;
	localparam int group_width = 3;
	localparam int oper_width = 5;
	localparam int imm12_width = 12;
	localparam int imm20_width = 20;

	// lsb of each field, immediates start at bit 0
	localparam int group_lsb = instr_width - group_width;
	localparam int ra_lsb = group_lsb - reg_index_width;
	localparam int rb_lsb = ra_lsb - reg_index_width;
	localparam int rc_lsb = rb_lsb - reg_index_width;
	localparam int reg_oper_lsb = rc_lsb - oper_width;
	localparam int ctrl_oper_lsb = ra_lsb - oper_width;

	// defined groups, 4 to 7 are undefined
	localparam logic [group_width-1:0] group_alu = group_width'(0);
	localparam logic [group_width-1:0] group_ctrl = group_width'(1);
	localparam logic [group_width-1:0] group_load = group_width'(2);
	localparam logic [group_width-1:0] group_store = group_width'(3);

	// defined opcodes per group, counted from 0
	localparam int num_alu_opers = 15;
	localparam int num_ctrl_opers = 3;
	localparam int num_load_opers = 9;
	localparam int num_store_opers = 9;

	typedef enum logic [2:0]
	{
		st_init,
		st_regular,
		st_change_pc,
		st_wait_mem_0,
		st_wait_mem_1
	} fetch_state_t;

	// same word, register layout or branch layout
	typedef union packed
	{
		struct packed
		{
			logic [group_width-1:0] group;
			logic [reg_index_width-1:0] ra;
			logic [reg_index_width-1:0] rb;
			logic [reg_index_width-1:0] rc;
			logic [oper_width-1:0] oper;
			logic [imm12_width-1:0] imm12;
		} reg_form;
		struct packed
		{
			logic [group_width-1:0] group;
			logic [reg_index_width-1:0] ra;
			logic [oper_width-1:0] oper;
			logic [imm20_width-1:0] imm20;
		} ctrl_form;
	} instr_word_t;

endpackage

/* hw/if_id_stage.sv */
`timescale 1ns/1ns

module if_id_stage
(
	input logic clk,
	input logic rst_n,
	output logic fetch_req,
	output logic [if_id_pkg::addr_width-1:0] fetch_addr,
	input logic instr_valid,
	input if_id_pkg::instr_word_t instr,
	input logic ex_stall,
	input logic [if_id_pkg::addr_width-1:0] computed_pc,
	output logic ex_valid,
	output logic [if_id_pkg::group_width-1:0] ex_group,
	output logic [if_id_pkg::oper_width-1:0] ex_oper,
	output logic [if_id_pkg::reg_index_width-1:0] ex_ra,
	output logic [if_id_pkg::reg_index_width-1:0] ex_rb,
	output logic [if_id_pkg::reg_index_width-1:0] ex_rc,
	output logic [if_id_pkg::addr_width-1:0] ex_imm,
	output logic [if_id_pkg::addr_width-1:0] ex_pc,
	input logic wb_stall,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_ra,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_rb,
	output logic [if_id_pkg::reg_index_width-1:0] ctrl_rc
);

	import if_id_pkg::*;

	// decoded fields of the word on instr
	logic [group_width-1:0] dec_group;
	logic [oper_width-1:0] dec_oper;
	logic [reg_index_width-1:0] dec_ra;
	logic [reg_index_width-1:0] dec_rb;
	logic [reg_index_width-1:0] dec_rc;
	logic [addr_width-1:0] dec_imm;
	logic dec_legal;

	instr_decoder u_decoder
	(
		.instr(instr),
		.group(dec_group),
		.oper(dec_oper),
		.ra(dec_ra),
		.rb(dec_rb),
		.rc(dec_rc),
		.imm(dec_imm),
		.legal(dec_legal)
	);

	fetch_sequencer u_sequencer
	(
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.ex_stall(ex_stall),
		.wb_stall(wb_stall),
		.computed_pc(computed_pc),
		.group(dec_group),
		.oper(dec_oper),
		.ra(dec_ra),
		.rb(dec_rb),
		.rc(dec_rc),
		.imm(dec_imm),
		.legal(dec_legal),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.ex_valid(ex_valid),
		.ex_group(ex_group),
		.ex_oper(ex_oper),
		.ex_ra(ex_ra),
		.ex_rb(ex_rb),
		.ex_rc(ex_rc),
		.ex_imm(ex_imm),
		.ex_pc(ex_pc),
		.ctrl_ra(ctrl_ra),
		.ctrl_rb(ctrl_rb),
		.ctrl_rc(ctrl_rc)
	);

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder
(
	input if_id_pkg::instr_word_t instr,
	output logic [if_id_pkg::group_width-1:0] group,
	output logic [if_id_pkg::oper_width-1:0] oper,
	output logic [if_id_pkg::reg_index_width-1:0] ra,
	output logic [if_id_pkg::reg_index_width-1:0] rb,
	output logic [if_id_pkg::reg_index_width-1:0] rc,
	output logic [if_id_pkg::addr_width-1:0] imm,
	output logic legal
);

	import if_id_pkg::*;

	logic [group_width-1:0] grp;
	logic imm12_sign;
	logic imm20_sign;

	// group and ra sit at the same place in both layouts
	assign grp = instr.reg_form.group;
	assign imm12_sign = instr.reg_form.imm12[imm12_width-1];
	assign imm20_sign = instr.ctrl_form.imm20[imm20_width-1];

	assign group = grp;
	assign ra = instr.reg_form.ra;

	always_comb
	begin
		if (grp == group_ctrl)
		begin
			// branches carry a wide offset and no rb/rc
			oper = instr.ctrl_form.oper;
			rb = '0;
			rc = '0;
			imm = {{(addr_width - imm20_width){imm20_sign}},
				instr.ctrl_form.imm20};
		end
		else
		begin
			oper = instr.reg_form.oper;
			rb = instr.reg_form.rb;
			rc = instr.reg_form.rc;
			imm = {{(addr_width - imm12_width){imm12_sign}},
				instr.reg_form.imm12};
		end
	end

	// opcode must be below the group's count
	always_comb
	begin
		case (grp)
			group_alu:
				legal = oper < oper_width'(num_alu_opers);
			group_ctrl:
				legal = oper < oper_width'(num_ctrl_opers);
			group_load:
				legal = oper < oper_width'(num_load_opers);
			group_store:
				legal = oper < oper_width'(num_store_opers);
			default:
				legal = 1'b0;
		endcase
	end

endmodule

/* if_id_stage.f */
hw/if_id_pkg.sv
hw/instr_decoder.sv
hw/fetch_sequencer.sv
hw/if_id_stage.sv
tb/tb_clock.sv
tb/if_id_tb.sv

/* tb/if_id_tb.sv */
`timescale 1ns/1ns

module if_id_tb;

	import if_id_pkg::*;

	localparam int prog_len = 12;
	localparam int watchdog_cycles = prog_len * 40 + 200;

	typedef struct packed
	{
		logic [group_width-1:0] group;
		logic [oper_width-1:0] oper;
		logic [reg_index_width-1:0] ra;
		logic [reg_index_width-1:0] rb;
		logic [reg_index_width-1:0] rc;
		logic [addr_width-1:0] imm;
		logic legal;
	} dec_t;

	logic clk;
	logic rst_n;
	logic fetch_req;
	logic [addr_width-1:0] fetch_addr;
	logic instr_valid;
	logic [instr_width-1:0] instr;
	logic ex_stall;
	logic [addr_width-1:0] computed_pc;
	logic ex_valid;
	logic [group_width-1:0] ex_group;
	logic [oper_width-1:0] ex_oper;
	logic [reg_index_width-1:0] ex_ra;
	logic [reg_index_width-1:0] ex_rb;
	logic [reg_index_width-1:0] ex_rc;
	logic [addr_width-1:0] ex_imm;
	logic [addr_width-1:0] ex_pc;
	logic wb_stall;
	logic [reg_index_width-1:0] ctrl_ra;
	logic [reg_index_width-1:0] ctrl_rb;
	logic [reg_index_width-1:0] ctrl_rc;

	logic [instr_width-1:0] prog [0:prog_len-1];
	int error_count;
	logic done;

	// cache model
	logic pend;
	logic [addr_width-1:0] pend_addr;
	int wb_cnt;

	// snapshot of the previous cycle, taken at the falling edge
	logic s_req;
	logic [addr_width-1:0] s_addr;
	logic s_consumed;
	logic p_ex_valid;
	logic p_stalled;
	logic p_wb_stall;
	logic p_hold_alu;
	logic [group_width+oper_width+3*reg_index_width-1:0] p_ex_fields;
	logic [addr_width-1:0] p_ex_imm;
	logic [addr_width-1:0] p_ex_pc;
	logic first_cycle;
	logic first_fetch_seen;
	logic [addr_width-1:0] exp_pc;
	int mem_left;

	tb_clock u_clock
	(
		.clk(clk),
		.rst_n(rst_n)
	);

	if_id_stage DUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.instr_valid(instr_valid),
		.instr(instr),
		.ex_stall(ex_stall),
		.computed_pc(computed_pc),
		.ex_valid(ex_valid),
		.ex_group(ex_group),
		.ex_oper(ex_oper),
		.ex_ra(ex_ra),
		.ex_rb(ex_rb),
		.ex_rc(ex_rc),
		.ex_imm(ex_imm),
		.ex_pc(ex_pc),
		.wb_stall(wb_stall),
		.ctrl_ra(ctrl_ra),
		.ctrl_rb(ctrl_rb),
		.ctrl_rc(ctrl_rc)
	);

	function automatic logic [instr_width-1:0] enc_reg(input int g, input int ra, input int rb,
		input int rc, input int op, input int imm12);
		return {3'(g), 4'(ra), 4'(rb), 4'(rc), 5'(op), 12'(imm12)};
	endfunction

	function automatic logic [instr_width-1:0] enc_ctrl(input int ra, input int op,
		input int imm20);
		return {3'd1, 4'(ra), 5'(op), 20'(imm20)};
	endfunction

	// expected decode straight from the two word layouts
	function automatic dec_t ref_decode(input logic [instr_width-1:0] w);
		dec_t d;
		int limit;
		d.group = w[instr_width-1 -: group_width];
		d.ra = w[ra_lsb +: reg_index_width];
		if (d.group == 3'd1)
		begin
			d.oper = w[ctrl_oper_lsb +: oper_width];
			d.rb = '0;
			d.rc = '0;
			d.imm = {{(addr_width - imm20_width){w[imm20_width-1]}}, w[imm20_width-1:0]};
		end
		else
		begin
			d.oper = w[reg_oper_lsb +: oper_width];
			d.rb = w[rb_lsb +: reg_index_width];
			d.rc = w[rc_lsb +: reg_index_width];
			d.imm = {{(addr_width - imm12_width){w[imm12_width-1]}}, w[imm12_width-1:0]};
		end
		case (d.group)
			3'd0: limit = 15;
			3'd1: limit = 3;
			3'd2: limit = 9;
			3'd3: limit = 9;
			default: limit = 0;
		endcase
		d.legal = int'(d.oper) < limit;
		return d;
	endfunction

	// words past the image read as zero
	function automatic logic [instr_width-1:0] fetch_word(input logic [addr_width-1:0] addr);
		if (addr[1:0] == 2'b00 && addr < addr_width'(prog_len * 4))
			return prog[int'(addr >> 2)];
		return '0;
	endfunction

	function automatic logic [addr_width-1:0] skip_illegal(input logic [addr_width-1:0] addr);
		logic [addr_width-1:0] a;
		dec_t d;
		a = addr;
		d = ref_decode(fetch_word(a));
		while (a < addr_width'(prog_len * 4) && !d.legal)
		begin
			a = a + 4;
			d = ref_decode(fetch_word(a));
		end
		return a;
	endfunction

	task automatic check_value(input string name, input logic [addr_width-1:0] expected,
		input logic [addr_width-1:0] actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("[ERROR] %s", what);
	endtask

	initial
	begin
		void'($urandom(36));
		instr_valid = 1'b0;
		instr = '0;
		ex_stall = 1'b0;
		computed_pc = '0;
		wb_stall = 1'b0;
		error_count = 0;
		done = 1'b0;
		pend = 1'b0;
		pend_addr = '0;
		wb_cnt = 0;
		prog[0] = enc_reg(0, 1, 2, 3, 0, 5);
		prog[1] = enc_reg(0, 4, 5, 6, 14, 12'hffd);
		// oper 20 is not an alu op
		prog[2] = enc_reg(0, 1, 1, 1, 20, 0);
		prog[3] = enc_reg(0, 15, 0, 9, 7, 12'h7ff);
		// branch over the next word
		prog[4] = enc_ctrl(2, 1, 1);
		prog[5] = enc_reg(0, 3, 3, 3, 2, 1);
		prog[6] = enc_reg(2, 7, 8, 0, 3, 12'hff8);
		prog[7] = enc_reg(0, 12, 13, 14, 1, 33);
		prog[8] = enc_reg(3, 9, 10, 11, 8, 16);
		prog[9] = enc_reg(5, 2, 2, 2, 0, 0);
		prog[10] = enc_reg(0, 0, 0, 0, 0, 0);
		prog[11] = enc_reg(0, 3, 6, 9, 12, 12'h800);
	end

	// cache and execute/write-back models
	always @(posedge clk)
	begin
		logic in_reset;
		in_reset = !rst_n;
		#1;
		if (in_reset)
		begin
			pend = 1'b0;
			instr_valid = 1'b0;
			ex_stall = 1'b0;
			wb_stall = 1'b0;
			wb_cnt = 0;
		end
		else
		begin
			// a new request is taken once the old answer is used up
			if (s_req && (!pend || s_consumed))
			begin
				pend = 1'b1;
				pend_addr = s_addr;
			end
			else if (!s_req && s_consumed)
				pend = 1'b0;
			instr = fetch_word(pend_addr);
			instr_valid = pend && ($urandom % 4 != 0);
			ex_stall = ($urandom % 4 == 0);
			if (ex_valid && ex_group == group_ctrl)
				computed_pc = ex_pc + (ex_imm << 2);
			if (ex_valid && (ex_group == group_load || ex_group == group_store))
				wb_cnt = $urandom % 6;
			else if (wb_cnt > 0)
				wb_cnt--;
			wb_stall = (wb_cnt != 0);
		end
	end

	// monitor and checks
	always @(negedge clk)
	begin
		logic [addr_width-1:0] addr;
		logic [addr_width-1:0] target;
		logic new_issue;
		dec_t r;
		dec_t c;
		if (!rst_n)
		begin
			check_value("fetch_req in reset", 0, 64'(fetch_req));
			if ($time > 8)
				check_value("ex_valid in reset", 0, 64'(ex_valid));
			s_req = 1'b0;
			s_consumed = 1'b0;
			p_ex_valid = 1'b0;
			p_stalled = 1'b0;
			p_wb_stall = 1'b0;
			p_hold_alu = 1'b0;
			first_cycle = 1'b1;
			first_fetch_seen = 1'b0;
			exp_pc = skip_illegal('0);
			mem_left = 0;
		end
		else
		begin
			if (first_cycle)
				check_value("ex_valid after reset", 0, 64'(ex_valid));
			first_cycle = 1'b0;
			if (!first_fetch_seen && fetch_req)
			begin
				check_value("first fetch_addr", 0, fetch_addr);
				first_fetch_seen = 1'b1;
			end
			if (p_hold_alu)
			begin
				check_value("ex_valid under stall", 1, 64'(ex_valid));
				check_value("ex fields under stall", 64'(p_ex_fields),
					64'({ex_group, ex_oper, ex_ra, ex_rb, ex_rc}));
				check_value("ex_imm under stall", p_ex_imm, ex_imm);
				check_value("ex_pc under stall", p_ex_pc, ex_pc);
			end
			new_issue = ex_valid && !(p_ex_valid && p_stalled);
			if (new_issue && !done)
			begin
				addr = (ex_group == group_ctrl) ? ex_pc - 4 : ex_pc;
				check_value("issue order", exp_pc, addr);
				r = ref_decode(fetch_word(addr));
				check_value("issued word legal", 1, 64'(r.legal));
				check_value("ex_group", 64'(r.group), 64'(ex_group));
				check_value("ex_oper", 64'(r.oper), 64'(ex_oper));
				check_value("ex_ra", 64'(r.ra), 64'(ex_ra));
				check_value("ex_rb", 64'(r.rb), 64'(ex_rb));
				check_value("ex_rc", 64'(r.rc), 64'(ex_rc));
				check_value("ex_imm", r.imm, ex_imm);
				if (mem_left > 0)
					report_failure("instruction issued inside the memory wait");
				if (p_wb_stall)
					report_failure("instruction issued while write-back stalled");
				if (r.group == 3'd1)
				begin
					target = addr + 4 + (r.imm << 2);
					check_value("redirect fetch_req", 1, 64'(fetch_req));
					check_value("redirect fetch_addr", target, fetch_addr);
					exp_pc = skip_illegal(target);
				end
				else
					exp_pc = skip_illegal(addr + 4);
				if (r.group == 3'd2 || r.group == 3'd3)
					mem_left = 2;
				if (addr == addr_width'((prog_len - 1) * 4))
					done = 1'b1;
			end
			else if (!ex_valid && mem_left > 0)
				mem_left--;
			if (ctrl_ra != 0 || ctrl_rb != 0 || ctrl_rc != 0)
			begin
				c = ref_decode(instr);
				check_value("ctrl_ra", 64'(c.ra), 64'(ctrl_ra));
				check_value("ctrl_rb", 64'(c.rb), 64'(ctrl_rb));
				check_value("ctrl_rc", 64'(c.rc), 64'(ctrl_rc));
			end
			s_req = fetch_req;
			s_addr = fetch_addr;
			s_consumed = instr_valid && !ex_stall;
			p_ex_valid = ex_valid;
			p_stalled = ex_stall && instr_valid;
			p_wb_stall = wb_stall;
			p_hold_alu = ex_valid && ex_group == group_alu && ex_stall && instr_valid;
			p_ex_fields = {ex_group, ex_oper, ex_ra, ex_rb, ex_rc};
			p_ex_imm = ex_imm;
			p_ex_pc = ex_pc;
		end
	end

	initial
	begin
		wait (done);
		repeat (3) @(posedge clk);
		$display("errors: %0d", error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("run hung: the last program word was never issued");
		$display("errors: %0d", error_count);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release reset just after the 16th rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule
